// ==== tb.f ====
raster_pkg.sv
wb_regs_pkg.sv
frame_buffer.sv
edge_setup.sv
tri_rasterizer.sv
frame_ctrl.sv
tri_regfile.sv
tri_gpu_top.sv
tb_top.sv

// ==== tb_top.sv ====
// testbench: clock, reset, watchdog, lfsr, frame model, bus tasks, check task and directed tests
`timescale 1ns/1ns

module tb_top import raster_pkg::*, wb_regs_pkg::*; ();

  localparam int CLK_NS    = 40;
  localparam int NUM_TESTS = 6;
  // per test, one full clear plus a full-screen box scan, then doubled
  localparam longint WD_NS = 64'(2 * NUM_TESTS) * 64'(2 * FB_DEPTH) * 64'(CLK_NS);

  logic       S_AXI_ACLK;
  logic       S_AXI_ARESETN;
  wb_req_t    wb_req;
  wb_rsp_t    wb_rsp;
  logic       vsync;
  logic [9:0] draw_x;
  logic [9:0] draw_y;
  logic [3:0] red;
  logic [3:0] green;
  logic [3:0] blue;

  logic [7:0]  model [FB_DEPTH];
  logic [31:0] lfsr_state = 32'hd861cfaf;
  int          err_count = 0;
  int          check_count = 0;
  int          tests_run = 0;

  tri_gpu_top u_dut (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .wb_req        (wb_req),
    .wb_rsp        (wb_rsp),
    .vsync         (vsync),
    .draw_x        (draw_x),
    .draw_y        (draw_y),
    .red           (red),
    .green         (green),
    .blue          (blue)
  );

  initial begin
    S_AXI_ACLK = 1'b0;
    forever #(CLK_NS / 2) S_AXI_ACLK = ~S_AXI_ACLK;
  end

  initial begin
    #(WD_NS);
    $display("timeout: tests did not finish within %0d ns", WD_NS);
    $display("TB FAILED");
    $finish;
  end

  ////////////////////
  // galois lfsr, one step per bit
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) lfsr_state = lfsr_state ^ 32'h80200003;
    return b;
  endfunction

  function automatic int rand_bits(int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) v = (v << 1) | int'(lfsr_bit());
    return v;
  endfunction

  function automatic int rand_range(int lo, int hi);
    return lo + rand_bits(16) % (hi - lo + 1);
  endfunction

  ////////////////////
  // compare and count
  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Fail t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests_run++;
    if (err_count == err_start) $display("%s: ok", name);
    else $display("%s: %0d errors", name, err_count - err_start);
  endtask

  ////////////////////
  // wishbone classic host, request held until ack
  task automatic wb_xfer(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                         output logic [31:0] rdat, output int waits);
    wb_req_t req;
    req     = '0;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = adr;
    req.dat = wdat;
    waits   = 0;
    @(posedge S_AXI_ACLK);
    wb_req <= req;
    @(negedge S_AXI_ACLK);
    while (!wb_rsp.ack) begin
      waits++;
      @(negedge S_AXI_ACLK);
    end
    rdat = wb_rsp.dat;
    // drop stb in the cycle after ack
    @(posedge S_AXI_ACLK);
    wb_req <= '0;
  endtask

  task automatic wb_write(input logic [3:0] adr, input logic [31:0] wdat, output int waits);
    logic [31:0] unused;
    wb_xfer(1'b1, adr, wdat, unused, waits);
  endtask

  task automatic wb_read(input logic [3:0] adr, output logic [31:0] rdat);
    int waits;
    wb_xfer(1'b0, adr, '0, rdat, waits);
  endtask

  task automatic wait_idle();
    logic [31:0] st;
    st = 32'h3;
    while (st[1:0] != 2'b00) wb_read(REG_STATUS, st);
  endtask

  task automatic pulse_vsync();
    @(posedge S_AXI_ACLK);
    vsync <= 1'b1;
    repeat (4) @(posedge S_AXI_ACLK);
    vsync <= 1'b0;
  endtask

  ////////////////////
  // triangle helpers
  function automatic triangle_t make_tri(int x1, int y1, int x2, int y2, int x3, int y3,
                                         logic [7:0] col);
    triangle_t t;
    t.v1.x  = X_W'(x1);
    t.v1.y  = Y_W'(y1);
    t.v2.x  = X_W'(x2);
    t.v2.y  = Y_W'(y2);
    t.v3.x  = X_W'(x3);
    t.v3.y  = Y_W'(y3);
    t.color = color_t'(col);
    return t;
  endfunction

  // stage registers then GO
  task automatic load_tri(input triangle_t t, output int go_waits);
    int w;
    wb_write(REG_V1X, 32'(t.v1.x), w);
    wb_write(REG_V1Y, 32'(t.v1.y), w);
    wb_write(REG_V2X, 32'(t.v2.x), w);
    wb_write(REG_V2Y, 32'(t.v2.y), w);
    wb_write(REG_V3X, 32'(t.v3.x), w);
    wb_write(REG_V3Y, 32'(t.v3.y), w);
    wb_write(REG_COLOR, 32'(t.color), w);
    wb_write(REG_GO, 32'h1, go_waits);
  endtask

  // min/max of the vertices, pulled onto the screen
  task automatic tri_box(input triangle_t t, output int xs, output int xe,
                         output int ys, output int ye);
    int xa[3];
    int ya[3];
    xa = '{int'(t.v1.x), int'(t.v2.x), int'(t.v3.x)};
    ya = '{int'(t.v1.y), int'(t.v2.y), int'(t.v3.y)};
    xs = xa[0];
    xe = xa[0];
    ys = ya[0];
    ye = ya[0];
    for (int i = 1; i < 3; i++) begin
      if (xa[i] < xs) xs = xa[i];
      if (xa[i] > xe) xe = xa[i];
      if (ya[i] < ys) ys = ya[i];
      if (ya[i] > ye) ye = ya[i];
    end
    if (xs > SCREEN_W - 1) xs = SCREEN_W - 1;
    if (xe > SCREEN_W - 1) xe = SCREEN_W - 1;
    if (ys > SCREEN_H - 1) ys = SCREEN_H - 1;
    if (ye > SCREEN_H - 1) ye = SCREEN_H - 1;
  endtask

  task automatic clear_model();
    for (int i = 0; i < FB_DEPTH; i++) model[i] = 8'h00;
  endtask

  // fill with the edge rule, painter's order
  task automatic draw_model(input triangle_t t);
    int vx[3];
    int vy[3];
    int a[3];
    int b[3];
    int c[3];
    int xs, xe, ys, ye;
    int w0, w1, w2;
    vx = '{int'(t.v1.x), int'(t.v2.x), int'(t.v3.x)};
    vy = '{int'(t.v1.y), int'(t.v2.y), int'(t.v3.y)};
    for (int i = 0; i < 3; i++) begin
      // edge from vertex i to the next one round the triangle
      a[i] = vy[i] - vy[(i + 1) % 3];
      b[i] = vx[(i + 1) % 3] - vx[i];
      c[i] = vx[i] * vy[(i + 1) % 3] - vx[(i + 1) % 3] * vy[i];
    end
    tri_box(t, xs, xe, ys, ye);
    for (int y = ys; y <= ye; y++) begin
      for (int x = xs; x <= xe; x++) begin
        w0 = a[0] * x + b[0] * y + c[0];
        w1 = a[1] * x + b[1] * y + c[1];
        w2 = a[2] * x + b[2] * y + c[2];
        if ((w0 >= 0 && w1 >= 0 && w2 >= 0) || (w0 <= 0 && w1 <= 0 && w2 <= 0))
          model[y * SCREEN_W + x] = t.color;
      end
    end
  endtask

  ////////////////////
  // scan-out sampling, odd draw coordinates
  task automatic check_pixel(input int px, input int py);
    logic [7:0]  col;
    logic [11:0] exp;
    @(posedge S_AXI_ACLK);
    draw_x <= 10'(2 * px + 1);
    draw_y <= 10'(2 * py + 1);
    @(negedge S_AXI_ACLK);
    col = model[py * SCREEN_W + px];
    // 3-3-2 padded with zeros to 4-4-4
    exp = {col[7:5], 1'b0, col[4:2], 1'b0, col[1:0], 2'b00};
    check($sformatf("rgb(%0d,%0d)", px, py), 32'({red, green, blue}), 32'(exp));
  endtask

  task automatic check_random(input triangle_t t, input int n);
    int xs, xe, ys, ye;
    tri_box(t, xs, xe, ys, ye);
    repeat (n) check_pixel(rand_range(xs, xe), rand_range(ys, ye));
  endtask

  task automatic check_screen(input int n);
    repeat (n) check_pixel(rand_range(0, SCREEN_W - 1), rand_range(0, SCREEN_H - 1));
  endtask

  ////////////////////
  // directed tests
  task automatic test_reset();
    int          e0;
    logic [31:0] st;
    e0 = err_count;
    wb_read(REG_STATUS, st);
    check("status after reset", st, 32'h2);
    wait_idle();
    wb_read(REG_STATUS, st);
    check("status after clear", st, 32'h0);
    check_pixel(0, 0);
    check_pixel(SCREEN_W - 1, 0);
    check_pixel(0, SCREEN_H - 1);
    check_pixel(SCREEN_W - 1, SCREEN_H - 1);
    check_screen(4);
    finish_test("reset and clear", e0);
  endtask

  task automatic test_regs();
    int          e0;
    int          w;
    logic [31:0] wd [7];
    logic [31:0] mask [7];
    logic [31:0] rd;
    e0   = err_count;
    mask = '{32'h1ff, 32'hff, 32'h1ff, 32'hff, 32'h1ff, 32'hff, 32'hff};
    for (int i = 0; i < 7; i++) begin
      wd[i] = 32'(rand_bits(32));
      wb_write(4'(i), wd[i], w);
    end
    // read back after all writes to catch aliasing
    for (int i = 0; i < 7; i++) begin
      wb_read(4'(i), rd);
      check($sformatf("reg %0d", i), rd, wd[i] & mask[i]);
    end
    wb_read(REG_GO, rd);
    check("go readback", rd, 32'h0);
    wb_write(REG_STATUS, 32'hffff_ffff, w);
    wb_read(REG_STATUS, rd);
    check("status after write", rd, 32'h0);
    finish_test("register readback", e0);
  endtask

  task automatic test_single();
    int        e0;
    int        w;
    triangle_t t;
    e0 = err_count;
    t  = make_tri(40, 30, 200, 60, 100, 180, 8'he5);
    load_tri(t, w);
    wait_idle();
    draw_model(t);
    check_pixel(40, 30);
    check_pixel(200, 60);
    check_pixel(100, 180);
    check_random(t, 64);
    finish_test("single triangle", e0);
  endtask

  task automatic test_overlap();
    int          e0;
    int          w;
    logic [31:0] st;
    triangle_t   ta;
    triangle_t   tb;
    e0 = err_count;
    ta = make_tri(20, 20, 220, 40, 60, 200, 8'h1c);
    tb = make_tri(120, 50, 300, 100, 150, 220, 8'he3);
    // a clear keeps the controller busy so the slot stays full
    pulse_vsync();
    clear_model();
    load_tri(ta, w);
    load_tri(tb, w);
    if (w < 2) begin
      err_count++;
      $display("second GO was acknowledged while the pending slot was still full");
    end
    // first drawing, second waiting
    wb_read(REG_STATUS, st);
    check("status after second go", st, 32'h3);
    wait_idle();
    draw_model(ta);
    draw_model(tb);
    check_random(ta, 32);
    check_random(tb, 32);
    finish_test("overlap and pending slot", e0);
  endtask

  task automatic test_vsync_clear();
    int          e0;
    logic [31:0] st;
    e0 = err_count;
    pulse_vsync();
    wb_read(REG_STATUS, st);
    check("status busy after vsync", 32'(st[STAT_BUSY]), 32'h1);
    wait_idle();
    clear_model();
    check_pixel(40, 30);
    check_pixel(200, 60);
    check_pixel(150, 120);
    check_screen(32);
    finish_test("vsync clear", e0);
  endtask

  task automatic test_clamp();
    int        e0;
    int        w;
    triangle_t t;
    e0 = err_count;
    t  = make_tri(100, 50, 500, 120, 200, 250, 8'h5a);
    load_tri(t, w);
    wait_idle();
    draw_model(t);
    check_pixel(100, 50);
    check_pixel(SCREEN_W - 1, SCREEN_H - 1);
    repeat (8) check_pixel(SCREEN_W - 1, rand_range(50, SCREEN_H - 1));
    repeat (8) check_pixel(rand_range(100, SCREEN_W - 1), SCREEN_H - 1);
    check_random(t, 48);
    finish_test("clamped triangle", e0);
  endtask

  ////////////////////
  // main sequence
  initial begin
    S_AXI_ARESETN = 1'b0;
    wb_req        = '0;
    vsync         = 1'b0;
    draw_x        = '0;
    draw_y        = '0;
    clear_model();
    repeat (16) @(posedge S_AXI_ACLK);
    S_AXI_ARESETN <= 1'b1;
    test_reset();
    test_regs();
    test_single();
    test_overlap();
    test_vsync_clear();
    test_clamp();
    $display("tests %0d, checks %0d, errors %0d", tests_run, check_count, err_count);
    if (err_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== tri_gpu_top.sv ====
// renderer top: register file, pipeline controller, edge setup, rasterizer, frame buffer
`timescale 1ns/1ns

module tri_gpu_top import raster_pkg::*, wb_regs_pkg::*; (
  input  logic       S_AXI_ACLK,
  input  logic       S_AXI_ARESETN,
  input  wb_req_t    wb_req,
  output wb_rsp_t    wb_rsp,
  input  logic       vsync,
  input  logic [9:0] draw_x,
  input  logic [9:0] draw_y,
  output logic [3:0] red,
  output logic [3:0] green,
  output logic [3:0] blue
);

  // pending slot handshake
  logic      tri_valid;
  logic      tri_ready;
  logic      busy;
  triangle_t pend_tri;

  // setup stage
  logic      setup_start;
  logic      setup_done;
  triangle_t setup_tri;
  setup_t    setup;

  // raster stage and write path
  logic      raster_start;
  logic      raster_done;
  fb_wr_t    raster_wr;
  fb_wr_t    fb_wr;

  tri_regfile u_regfile (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .wb_req        (wb_req),
    .wb_rsp        (wb_rsp),
    .tri_valid     (tri_valid),
    .tri_data      (pend_tri),
    .tri_ready     (tri_ready),
    .busy          (busy)
  );

  frame_ctrl u_ctrl (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .vsync         (vsync),
    .tri_valid     (tri_valid),
    .tri_data      (pend_tri),
    .tri_ready     (tri_ready),
    .busy          (busy),
    .setup_start   (setup_start),
    .setup_tri     (setup_tri),
    .setup_done    (setup_done),
    .raster_start  (raster_start),
    .raster_done   (raster_done),
    .raster_wr     (raster_wr),
    .fb_wr         (fb_wr)
  );

  edge_setup u_setup (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .start         (setup_start),
    .tri_data      (setup_tri),
    .done          (setup_done),
    .setup         (setup)
  );

  tri_rasterizer u_raster (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .start         (raster_start),
    .setup         (setup),
    .done          (raster_done),
    .fb_wr         (raster_wr)
  );

  frame_buffer u_fb (
    .S_AXI_ACLK (S_AXI_ACLK),
    .fb_wr      (fb_wr),
    .draw_x     (draw_x),
    .draw_y     (draw_y),
    .red        (red),
    .green      (green),
    .blue       (blue)
  );

endmodule

// ==== tri_regfile.sv ====
// wishbone classic slave: staging registers, one-entry pending triangle slot, status read-back
`timescale 1ns/1ns

module tri_regfile import raster_pkg::*, wb_regs_pkg::*; (
  input  logic      S_AXI_ACLK,
  input  logic      S_AXI_ARESETN,
  input  wb_req_t   wb_req,
  output wb_rsp_t   wb_rsp,
  output logic      tri_valid,
  output triangle_t tri_data,
  input  logic      tri_ready,
  input  logic      busy
);

  reg_addr_e           req_addr;
  logic                hit;
  logic                go_wr;
  logic                accept;
  logic                wr_acc;
  logic                go_acc;
  logic                ack_q;
  logic [WB_DAT_W-1:0] rd_data;
  logic [WB_DAT_W-1:0] rd_q;
  triangle_t           stg;
  triangle_t           pend;

  assign req_addr = reg_addr_e'(wb_req.adr);

  ////////////////////
  // request decode
  // ack cycle itself is not a new request
  assign hit    = wb_req.cyc && wb_req.stb && !ack_q;
  assign go_wr  = wb_req.we && (req_addr == REG_GO);
  // GO waits while the slot is full, unless the controller takes it this cycle
  assign accept = hit && !(go_wr && tri_valid && !tri_ready);
  assign wr_acc = accept && wb_req.we;
  assign go_acc = wr_acc && (req_addr == REG_GO);

  // read mux, fields zero-extended
  always_comb begin
    rd_data = '0;
    case (req_addr)
      REG_V1X:    rd_data[X_W-1:0] = stg.v1.x;
      REG_V1Y:    rd_data[Y_W-1:0] = stg.v1.y;
      REG_V2X:    rd_data[X_W-1:0] = stg.v2.x;
      REG_V2Y:    rd_data[Y_W-1:0] = stg.v2.y;
      REG_V3X:    rd_data[X_W-1:0] = stg.v3.x;
      REG_V3Y:    rd_data[Y_W-1:0] = stg.v3.y;
      REG_COLOR:  rd_data[7:0]     = stg.color;
      REG_STATUS: begin
        rd_data[STAT_PENDING] = tri_valid;
        rd_data[STAT_BUSY]    = busy;
      end
      // GO and unmapped words read 0
      default: ;
    endcase
  end

  ////////////////////
  // ack and pending flag
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      ack_q     <= 1'b0;
      tri_valid <= 1'b0;
    end else begin
      ack_q <= accept;
      if (go_acc) begin
        tri_valid <= 1'b1;
      end else if (tri_valid && tri_ready) begin
        tri_valid <= 1'b0;
      end
    end
  end

  // staging regs, slot contents, read data
  always_ff @(posedge S_AXI_ACLK) begin
    if (wr_acc) begin
      case (req_addr)
        REG_V1X:   stg.v1.x  <= wb_req.dat[X_W-1:0];
        REG_V1Y:   stg.v1.y  <= wb_req.dat[Y_W-1:0];
        REG_V2X:   stg.v2.x  <= wb_req.dat[X_W-1:0];
        REG_V2Y:   stg.v2.y  <= wb_req.dat[Y_W-1:0];
        REG_V3X:   stg.v3.x  <= wb_req.dat[X_W-1:0];
        REG_V3Y:   stg.v3.y  <= wb_req.dat[Y_W-1:0];
        REG_COLOR: stg.color <= color_t'(wb_req.dat[7:0]);
        default: ;
      endcase
    end
    if (go_acc) begin
      pend <= stg;
    end
    if (accept && !wb_req.we) begin
      rd_q <= rd_data;
    end
  end

  assign wb_rsp   = '{ack: ack_q, dat: rd_q};
  assign tri_data = pend;

  // every ack answers a strobe seen the cycle before
  a_ack_after_req: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    ack_q |-> $past(wb_req.cyc && wb_req.stb));

  // slot holds its triangle until the controller takes it
  a_valid_held: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    tri_valid && !tri_ready |=> tri_valid && $stable(tri_data));

endmodule

// ==== frame_ctrl.sv ====
// pipeline FSM, vsync synchronizer and edge detect, clear sweep, frame-write mux
`timescale 1ns/1ns

module frame_ctrl import raster_pkg::*; (
  input  logic      S_AXI_ACLK,
  input  logic      S_AXI_ARESETN,
  input  logic      vsync,
  input  logic      tri_valid,
  input  triangle_t tri_data,
  output logic      tri_ready,
  output logic      busy,
  output logic      setup_start,
  output triangle_t setup_tri,
  input  logic      setup_done,
  output logic      raster_start,
  input  logic      raster_done,
  input  fb_wr_t    raster_wr,
  output fb_wr_t    fb_wr
);

  ctrl_state_e          state;
  logic                 vs_meta;
  logic                 vs_sync;
  logic                 vs_prev;
  logic                 vs_rise;
  logic [FB_ADDR_W-1:0] clr_addr;
  fb_wr_t               clr_wr;

  ////////////////////
  // vsync: two flops, then rising edge
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      vs_meta <= 1'b0;
      vs_sync <= 1'b0;
      vs_prev <= 1'b0;
    end else begin
      vs_meta <= vsync;
      vs_sync <= vs_meta;
      vs_prev <= vs_sync;
    end
  end

  assign vs_rise = vs_sync && !vs_prev;

  assign tri_ready = (state == wait_tri);
  assign busy      = (state != wait_tri);

  ////////////////////
  // controller
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      state        <= clear_buf;
      clr_addr     <= '0;
      clr_wr       <= '0;
      setup_start  <= 1'b0;
      raster_start <= 1'b0;
    end else begin
      // start strobes last one cycle
      setup_start  <= 1'b0;
      raster_start <= 1'b0;
      case (state)
        clear_buf: begin
          // last write is still on the port in the exit cycle
          if (clr_addr == FB_ADDR_W'(FB_DEPTH)) begin
            clr_wr.we <= 1'b0;
            state     <= wait_tri;
          end else begin
            clr_wr   <= '{we: 1'b1, addr: clr_addr, color: CLEAR_COLOR};
            clr_addr <= clr_addr + 1'b1;
          end
        end
        wait_tri: begin
          // tri_ready is high here, so a valid triangle is taken first
          if (tri_valid) begin
            setup_start <= 1'b1;
            state       <= calc_edge;
          end else if (vs_rise) begin
            clr_addr <= '0;
            state    <= clear_buf;
          end
        end
        calc_edge: begin
          if (setup_done) begin
            raster_start <= 1'b1;
            state        <= rasterize;
          end
        end
        rasterize: begin
          if (raster_done) begin
            state <= wait_tri;
          end
        end
      endcase
    end
  end

  // triangle held for setup
  always_ff @(posedge S_AXI_ACLK) begin
    if (tri_valid && tri_ready) begin
      setup_tri <= tri_data;
    end
  end

  // frame-write mux
  assign fb_wr = (state == clear_buf) ? clr_wr : raster_wr;

  // no source may write past the last cell
  a_fb_addr_range: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    fb_wr.we |-> fb_wr.addr < FB_ADDR_W'(FB_DEPTH));

endmodule

// ==== tri_rasterizer.sv ====
// bounding-box scan: per-pixel edge test and frame write of covered pixels
`timescale 1ns/1ns

module tri_rasterizer import raster_pkg::*; (
  input  logic   S_AXI_ACLK,
  input  logic   S_AXI_ARESETN,
  input  logic   start,
  input  setup_t setup,
  output logic   done,
  output fb_wr_t fb_wr
);

  logic                 active;
  coord_x_t             x;
  coord_y_t             y;
  logic signed [20:0]   w1;
  logic signed [20:0]   w2;
  logic signed [20:0]   w3;
  logic                 covered;
  logic                 last_pix;
  logic [FB_ADDR_W-1:0] pix_addr;
  logic                 wr_we;
  logic [FB_ADDR_W-1:0] wr_addr;
  color_t               wr_color;

  // a*x + b*y + c, all signed
  function automatic logic signed [20:0] eval_w(edge_t e, coord_x_t px, coord_y_t py);
    return e.a * $signed({1'b0, px}) + e.b * $signed({1'b0, py}) + e.c;
  endfunction

  ////////////////////
  // edge test, either winding
  assign w1 = eval_w(setup.e1, x, y);
  assign w2 = eval_w(setup.e2, x, y);
  assign w3 = eval_w(setup.e3, x, y);

  assign covered = (w1 >= 0 && w2 >= 0 && w3 >= 0) || (w1 <= 0 && w2 <= 0 && w3 <= 0);
  assign last_pix = (x == setup.box.x_end) && (y == setup.box.y_end);
  assign pix_addr = FB_ADDR_W'(y) * FB_ADDR_W'(SCREEN_W) + FB_ADDR_W'(x);

  // scan control
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      active <= 1'b0;
      done   <= 1'b0;
      wr_we  <= 1'b0;
    end else begin
      done  <= 1'b0;
      wr_we <= active && covered;
      if (start) begin
        active <= 1'b1;
      end else if (active && last_pix) begin
        // done lines up with the last write
        active <= 1'b0;
        done   <= 1'b1;
      end
    end
  end

  // row-major walk, one pixel per clock
  always_ff @(posedge S_AXI_ACLK) begin
    if (start) begin
      x <= setup.box.x_start;
      y <= setup.box.y_start;
    end else if (active) begin
      wr_addr  <= pix_addr;
      wr_color <= setup.color;
      if (x == setup.box.x_end) begin
        x <= setup.box.x_start;
        y <= y + 1'b1;
      end else begin
        x <= x + 1'b1;
      end
    end
  end

  assign fb_wr = '{we: wr_we, addr: wr_addr, color: wr_color};

  // setup is steady for the scan, so every write lands in its box
  a_wr_in_box: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    fb_wr.we |-> (fb_wr.addr % SCREEN_W) >= setup.box.x_start &&
                 (fb_wr.addr % SCREEN_W) <= setup.box.x_end &&
                 (fb_wr.addr / SCREEN_W) >= setup.box.y_start &&
                 (fb_wr.addr / SCREEN_W) <= setup.box.y_end);

endmodule

// ==== edge_setup.sv ====
// two-stage triangle setup: three edge equations, then the clamped bounding box
`timescale 1ns/1ns

module edge_setup import raster_pkg::*; (
  input  logic      S_AXI_ACLK,
  input  logic      S_AXI_ARESETN,
  input  logic      start,
  input  triangle_t tri_data,
  output logic      done,
  output setup_t    setup
);

  triangle_t tri_q;
  logic      s1_vld;
  bbox_t     box_c;

  // edge vi -> vj; a = yi-yj, b = xj-xi, c = xi*yj - xj*yi
  // 20-bit unsigned math, truncation leaves two's complement
  function automatic edge_t edge_of(vertex_t vi, vertex_t vj);
    edge_t       e;
    logic [19:0] p_ij;
    logic [19:0] p_ji;
    p_ij = 20'(vi.x) * 20'(vj.y);
    p_ji = 20'(vj.x) * 20'(vi.y);
    e.a  = 10'({2'b00, vi.y} - {2'b00, vj.y});
    e.b  = 10'({1'b0, vj.x} - {1'b0, vi.x});
    e.c  = 18'(p_ij - p_ji);
    return e;
  endfunction

  function automatic coord_x_t min3(coord_x_t p, coord_x_t q, coord_x_t r);
    coord_x_t m;
    m = (p < q) ? p : q;
    return (m < r) ? m : r;
  endfunction

  function automatic coord_x_t max3(coord_x_t p, coord_x_t q, coord_x_t r);
    coord_x_t m;
    m = (p > q) ? p : q;
    return (m > r) ? m : r;
  endfunction

  // pull into screen range
  function automatic coord_x_t clamp(coord_x_t v, int lim);
    return (v > lim) ? X_W'(lim) : v;
  endfunction

  ////////////////////
  // bbox from the latched vertices, y widened to share min3/max3
  always_comb begin
    box_c.x_start = clamp(min3(tri_q.v1.x, tri_q.v2.x, tri_q.v3.x), SCREEN_W - 1);
    box_c.x_end   = clamp(max3(tri_q.v1.x, tri_q.v2.x, tri_q.v3.x), SCREEN_W - 1);
    box_c.y_start = Y_W'(clamp(min3(X_W'(tri_q.v1.y), X_W'(tri_q.v2.y), X_W'(tri_q.v3.y)),
                               SCREEN_H - 1));
    box_c.y_end   = Y_W'(clamp(max3(X_W'(tri_q.v1.y), X_W'(tri_q.v2.y), X_W'(tri_q.v3.y)),
                               SCREEN_H - 1));
  end

  // stage flags
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      s1_vld <= 1'b0;
      done   <= 1'b0;
    end else begin
      s1_vld <= start;
      done   <= s1_vld;
    end
  end

  // stage 1 edges, stage 2 box and colour
  always_ff @(posedge S_AXI_ACLK) begin
    if (start) begin
      tri_q    <= tri_data;
      setup.e1 <= edge_of(tri_data.v1, tri_data.v2);
      setup.e2 <= edge_of(tri_data.v2, tri_data.v3);
      setup.e3 <= edge_of(tri_data.v3, tri_data.v1);
    end
    if (s1_vld) begin
      setup.box   <= box_c;
      setup.color <= tri_q.color;
    end
  end

endmodule

// ==== frame_buffer.sv ====
// pixel memory: clocked write port, combinational scan-out read with 3-3-2 to 4-4-4 expansion
`timescale 1ns/1ns

module frame_buffer import raster_pkg::*; (
  input  logic       S_AXI_ACLK,
  input  fb_wr_t     fb_wr,
  input  logic [9:0] draw_x,
  input  logic [9:0] draw_y,
  output logic [3:0] red,
  output logic [3:0] green,
  output logic [3:0] blue
);

  color_t               mem [FB_DEPTH];
  logic [8:0]           rd_x;
  logic [8:0]           rd_y;
  logic                 in_frame;
  logic [FB_ADDR_W-1:0] rd_addr;
  color_t               pix;

  ////////////////////
  // write side
  always_ff @(posedge S_AXI_ACLK) begin
    if (fb_wr.we) begin
      mem[fb_wr.addr] <= fb_wr.color;
    end
  end

  ////////////////////
  // scan-out, each cell shown as 2x2
  assign rd_x = draw_x[9:1];
  assign rd_y = draw_y[9:1];

  // blanking rows and columns fall outside the frame
  assign in_frame = (rd_x < SCREEN_W) && (rd_y < SCREEN_H);
  assign rd_addr  = FB_ADDR_W'(rd_y) * FB_ADDR_W'(SCREEN_W) + FB_ADDR_W'(rd_x);

  // no clock on the read path
  assign pix = in_frame ? mem[rd_addr] : CLEAR_COLOR;

  // pad each channel to 4 bits with zeros
  assign red   = {pix.r, 1'b0};
  assign green = {pix.g, 1'b0};
  assign blue  = {pix.b, 2'b00};

endmodule

// ==== wb_regs_pkg.sv ====
// wishbone request/response structs, register map and status bit positions
package wb_regs_pkg;

  localparam int WB_ADR_W = 4;
  localparam int WB_DAT_W = 32;

  ////////////////////
  // host to slave, held until ack
  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [WB_ADR_W-1:0] adr;
    logic [WB_DAT_W-1:0] dat;
  } wb_req_t;

  // slave to host
  typedef struct packed {
    logic                ack;
    logic [WB_DAT_W-1:0] dat;
  } wb_rsp_t;

  ////////////////////
  // word addresses
  typedef enum logic [WB_ADR_W-1:0] {
    REG_V1X    = 4'd0,
    REG_V1Y    = 4'd1,
    REG_V2X    = 4'd2,
    REG_V2Y    = 4'd3,
    REG_V3X    = 4'd4,
    REG_V3Y    = 4'd5,
    REG_COLOR  = 4'd6,
    REG_GO     = 4'd7,
    REG_STATUS = 4'd8
  } reg_addr_e;

  // status word bits
  localparam int STAT_PENDING = 0;
  localparam int STAT_BUSY    = 1;

endpackage

// ==== raster_pkg.sv ====
// frame geometry, pixel and triangle types, setup and write-port structs, controller states
package raster_pkg;

  ////////////////////
  // frame geometry, 320x240 at 8 bpp
  localparam int SCREEN_W  = 320;
  localparam int SCREEN_H  = 240;
  localparam int FB_DEPTH  = SCREEN_W * SCREEN_H;
  localparam int FB_ADDR_W = 17;
  localparam int X_W       = 9;
  localparam int Y_W       = 8;

  typedef logic [X_W-1:0] coord_x_t;
  typedef logic [Y_W-1:0] coord_y_t;

  // 3-3-2 colour, red in the top bits
  typedef struct packed {
    logic [2:0] r;
    logic [2:0] g;
    logic [1:0] b;
  } color_t;

  // black
  localparam color_t CLEAR_COLOR = '0;

  ////////////////////
  // triangle as loaded by the host
  typedef struct packed {
    coord_x_t x;
    coord_y_t y;
  } vertex_t;

  typedef struct packed {
    vertex_t v1;
    vertex_t v2;
    vertex_t v3;
    color_t  color;
  } triangle_t;

  // w = a*x + b*y + c
  typedef struct packed {
    logic signed [9:0]  a;
    logic signed [9:0]  b;
    logic signed [17:0] c;
  } edge_t;

  // inclusive pixel bounds
  typedef struct packed {
    coord_x_t x_start;
    coord_x_t x_end;
    coord_y_t y_start;
    coord_y_t y_end;
  } bbox_t;

  typedef struct packed {
    edge_t  e1;
    edge_t  e2;
    edge_t  e3;
    bbox_t  box;
    color_t color;
  } setup_t;

  // one frame-buffer write
  typedef struct packed {
    logic                 we;
    logic [FB_ADDR_W-1:0] addr;
    color_t               color;
  } fb_wr_t;

  typedef enum logic [1:0] {
    clear_buf,
    wait_tri,
    calc_edge,
    rasterize
  } ctrl_state_e;

endpackage
